// File: rioPkg.sv
/*
    Remote I/O shared definitions
    frame layout, header words, timing constants and counter widths
*/
`default_nettype none

package rioPkg;

    // frame geometry
    localparam int frameBits = 144;
    localparam int jointCount = 2;

    // header words after byte swap
    localparam logic [31:0] rxHeader = 32'h74697277;
    localparam logic [31:0] txHeaderData = 32'h64617461;
    localparam logic [31:0] txHeaderEstop = 32'h65737470;

    // timing, all in sysclk cycles
    localparam int timeoutCycles = 5000;
    localparam int pwmPeriod = 100;
    localparam int freqGate = 1000;

    // stepper phase accumulator
    localparam int phaseBits = 24;
    // largest increment still leaves an idle cycle between two steps
    localparam logic [31:0] stepAddMax = 32'((1 << (phaseBits - 1)) - 1);

    // counter widths
    localparam int bitCountWidth = $clog2(frameBits + 1);
    localparam int timeoutWidth = $clog2(timeoutCycles + 1);
    localparam int pwmWidth = $clog2(pwmPeriod + 1);
    localparam int freqGateWidth = $clog2(freqGate);

    // rx field lsb positions, header at the top
    localparam int rxHeaderLsb = 112;
    localparam int rxCmd0Lsb = 80;
    localparam int rxCmd1Lsb = 48;
    localparam int rxSetPointLsb = 16;
    localparam int rxEnableLsb = 8;
    localparam int rxDoutLsb = 0;

    // tx field lsb positions, lowest byte stays zero
    localparam int txHeaderLsb = 112;
    localparam int txFeedback0Lsb = 80;
    localparam int txFeedback1Lsb = 48;
    localparam int txProcessLsb = 16;
    localparam int txDinLsb = 8;

    // 32-bit fields travel least significant byte first
    function automatic logic [31:0] byteSwap(input logic [31:0] word);
        return {word[7:0], word[15:8], word[23:16], word[31:24]};
    endfunction

endpackage

`default_nettype wire

// File: spiSlave.sv
/*
    SPI mode 0 slave for the remote I/O frame
    shifts one fixed-length frame each way, checks the header on release
    and raises linkError when valid frames stop arriving
*/
`default_nettype none

module spiSlave import rioPkg::*; (
    input  logic                 sysclk,
    input  logic                 reset,
    input  logic                 spiSck,
    input  logic                 spiSsel,
    input  logic                 spiMosi,
    output logic                 spiMiso,
    input  logic [frameBits-1:0] txFrame,
    output logic [frameBits-1:0] rxFrame,
    output logic                 rxValid,
    output logic                 linkError
);

    // bits 0 and 1 synchronize, bit 2 keeps the last value for edge detection
    logic [2:0] sckSync;
    logic [2:0] sselSync;
    logic [1:0] mosiSync;

    logic sckRise;
    logic sckFall;
    logic sselRise;
    logic sselFall;
    logic sselActive;
    logic frameGood;

    logic [frameBits-1:0] rxShift;
    logic [frameBits-1:0] txShift;
    logic [bitCountWidth-1:0] bitCount;
    logic overrun;
    logic [timeoutWidth-1:0] timeoutCount;

    always_ff @(posedge sysclk) begin
        if (reset) begin
            sckSync <= '0;
            sselSync <= '1;
            mosiSync <= '0;
        end else begin
            sckSync <= {sckSync[1:0], spiSck};
            sselSync <= {sselSync[1:0], spiSsel};
            mosiSync <= {mosiSync[0], spiMosi};
        end
    end

    assign sckRise = (sckSync[2:1] == 2'b01);
    assign sckFall = (sckSync[2:1] == 2'b10);
    assign sselRise = (sselSync[2:1] == 2'b01);
    assign sselFall = (sselSync[2:1] == 2'b10);
    assign sselActive = !sselSync[1];

    assign frameGood = (bitCount == bitCountWidth'(frameBits)) && !overrun
                       && (byteSwap(rxShift[rxHeaderLsb +: 32]) == rxHeader);

    // data path, MSB first in both directions
    always_ff @(posedge sysclk) begin
        if (sselFall) begin
            txShift <= txFrame;
        end else if (sselActive && sckFall) begin
            txShift <= {txShift[frameBits-2:0], 1'b0};
        end
        if (sselActive && sckRise) begin
            rxShift <= {rxShift[frameBits-2:0], mosiSync[1]};
        end
    end

    assign spiMiso = txShift[frameBits-1];

    always_ff @(posedge sysclk) begin
        if (reset) begin
            bitCount <= '0;
            overrun <= 1'b0;
            rxValid <= 1'b0;
            rxFrame <= '0;
        end else begin
            rxValid <= 1'b0;
            if (sselFall) begin
                bitCount <= '0;
                overrun <= 1'b0;
            end else if (sselActive && sckRise) begin
                // extra clocks mark the frame bad instead of counting on
                if (bitCount == bitCountWidth'(frameBits)) begin
                    overrun <= 1'b1;
                end else begin
                    bitCount <= bitCount + 1'b1;
                end
            end
            if (sselRise && frameGood) begin
                rxFrame <= rxShift;
                rxValid <= 1'b1;
            end
        end
    end

    // link watchdog
    always_ff @(posedge sysclk) begin
        if (reset) begin
            timeoutCount <= '0;
            linkError <= 1'b0;
        end else if (rxValid) begin
            timeoutCount <= '0;
            linkError <= 1'b0;
        end else if (timeoutCount != timeoutWidth'(timeoutCycles)) begin
            timeoutCount <= timeoutCount + 1'b1;
            if (timeoutCount == timeoutWidth'(timeoutCycles - 1)) begin
                linkError <= 1'b1;
            end
        end
    end

    rxValidSingle: assert property (@(posedge sysclk) disable iff (reset)
        rxValid |=> !rxValid)
        else $error("rxValid held for more than one cycle");

    bitCountRange: assert property (@(posedge sysclk) disable iff (reset)
        bitCount <= bitCountWidth'(frameBits))
        else $error("bit count beyond frame length");

endmodule

`default_nettype wire

// File: frameMapper.sv
/*
    Frame mapper
    latches host commands from the received frame, gates enables with the
    link error and packs feedback into the reply frame
*/
`default_nettype none

module frameMapper import rioPkg::*; (
    input  logic                  sysclk,
    input  logic                  reset,
    input  logic [frameBits-1:0]  rxFrame,
    input  logic                  rxValid,
    input  logic                  linkError,
    output logic signed [31:0]    freqCmd0,
    output logic signed [31:0]    freqCmd1,
    output logic signed [31:0]    setPoint,
    output logic [jointCount-1:0] jointEnable,
    output logic                  pwmDisable,
    output logic                  ena,
    output logic [7:0]            dout,
    input  logic signed [31:0]    feedback0,
    input  logic signed [31:0]    feedback1,
    input  logic signed [31:0]    processVariable,
    input  logic [7:0]            din,
    output logic [frameBits-1:0]  txFrame
);

    logic [jointCount-1:0] enableBits;
    logic [31:0] txHeader;

    always_ff @(posedge sysclk) begin
        if (reset) begin
            freqCmd0 <= '0;
            freqCmd1 <= '0;
            setPoint <= '0;
            enableBits <= '0;
            dout <= '0;
            txHeader <= txHeaderData;
        end else begin
            txHeader <= linkError ? txHeaderEstop : txHeaderData;
            if (rxValid) begin
                freqCmd0 <= byteSwap(rxFrame[rxCmd0Lsb +: 32]);
                freqCmd1 <= byteSwap(rxFrame[rxCmd1Lsb +: 32]);
                setPoint <= byteSwap(rxFrame[rxSetPointLsb +: 32]);
                enableBits <= rxFrame[rxEnableLsb +: jointCount];
                dout <= rxFrame[rxDoutLsb +: 8];
            end
        end
    end

    // error overrides every motion output, digital outputs stay as sent
    assign jointEnable = enableBits & {jointCount{!linkError}};
    assign ena = (|enableBits) && !linkError;
    assign pwmDisable = linkError;

    always_comb begin
        // unused low byte goes out as zero
        txFrame = '0;
        txFrame[txHeaderLsb +: 32] = byteSwap(txHeader);
        txFrame[txFeedback0Lsb +: 32] = byteSwap(feedback0);
        txFrame[txFeedback1Lsb +: 32] = byteSwap(feedback1);
        txFrame[txProcessLsb +: 32] = byteSwap(processVariable);
        txFrame[txDinLsb +: 8] = din;
    end

endmodule

`default_nettype wire

// File: jointStepper.sv
/*
    Step/direction generator
    phase accumulator on the command magnitude, one step per carry,
    with an up/down position counter as feedback
*/
`default_nettype none

module jointStepper import rioPkg::*; (
    input  logic               sysclk,
    input  logic               reset,
    input  logic               enable,
    input  logic signed [31:0] freqCmd,
    output logic               stp,
    output logic               dir,
    output logic signed [31:0] feedback
);

    logic [31:0] magnitude;
    logic [phaseBits-1:0] stepAdd;
    logic [phaseBits-1:0] phase;
    logic [phaseBits:0] phaseSum;
    logic carry;

    assign magnitude = freqCmd[31] ? 32'(-freqCmd) : 32'(freqCmd);

    // clamp so a carry can never follow a carry
    assign stepAdd = (magnitude > stepAddMax) ? stepAddMax[phaseBits-1:0]
                                              : magnitude[phaseBits-1:0];

    assign phaseSum = {1'b0, phase} + {1'b0, stepAdd};
    assign carry = phaseSum[phaseBits];

    always_ff @(posedge sysclk) begin
        if (reset) begin
            phase <= '0;
            stp <= 1'b0;
            dir <= 1'b0;
            feedback <= '0;
        end else if (enable) begin
            phase <= phaseSum[phaseBits-1:0];
            stp <= carry;
            // dir high means negative travel
            dir <= freqCmd[31];
            if (carry) begin
                if (freqCmd[31]) begin
                    feedback <= feedback - 1;
                end else begin
                    feedback <= feedback + 1;
                end
            end
        end else begin
            // phase and dir hold while disabled
            stp <= 1'b0;
        end
    end

    stpSingle: assert property (@(posedge sysclk) disable iff (reset)
        stp |=> !stp)
        else $error("step pulse longer than one cycle");

endmodule

`default_nettype wire

// File: pwmOut.sv
/*
    Fixed-period PWM generator
    duty is the setpoint in cycles, clamped to the period
*/
`default_nettype none

module pwmOut import rioPkg::*; (
    input  logic               sysclk,
    input  logic               reset,
    input  logic signed [31:0] setPoint,
    input  logic               disabled,
    output logic               pwm
);

    logic [pwmWidth-1:0] periodCount;
    logic [pwmWidth-1:0] duty;

    // negative counts as zero, above the period as always on
    always_comb begin
        if (setPoint < 0) begin
            duty = '0;
        end else if (setPoint > pwmPeriod) begin
            duty = pwmWidth'(pwmPeriod);
        end else begin
            duty = setPoint[pwmWidth-1:0];
        end
    end

    always_ff @(posedge sysclk) begin
        if (reset) begin
            periodCount <= '0;
            pwm <= 1'b0;
        end else begin
            if (periodCount == pwmWidth'(pwmPeriod - 1)) begin
                periodCount <= '0;
            end else begin
                periodCount <= periodCount + 1'b1;
            end
            pwm <= !disabled && (periodCount < duty);
        end
    end

endmodule

`default_nettype wire

// File: freqCounter.sv
/*
    Input frequency counter
    counts synchronized rising edges over a fixed gate window
*/
`default_nettype none

module freqCounter import rioPkg::*; (
    input  logic               sysclk,
    input  logic               reset,
    input  logic               signalIn,
    output logic signed [31:0] frequency
);

    logic [2:0] signalSync;
    logic rise;
    logic [freqGateWidth-1:0] gateCount;
    logic [freqGateWidth-1:0] edgeCount;

    assign rise = (signalSync[2:1] == 2'b01);

    always_ff @(posedge sysclk) begin
        if (reset) begin
            signalSync <= '0;
            gateCount <= '0;
            edgeCount <= '0;
            frequency <= '0;
        end else begin
            signalSync <= {signalSync[1:0], signalIn};
            if (gateCount == freqGateWidth'(freqGate - 1)) begin
                // window closes, include an edge seen in the last cycle
                gateCount <= '0;
                frequency <= 32'(edgeCount) + 32'(rise);
                edgeCount <= '0;
            end else begin
                gateCount <= gateCount + 1'b1;
                edgeCount <= edgeCount + freqGateWidth'(rise);
            end
        end
    end

endmodule

`default_nettype wire

// File: rioTop.sv
/*
    Remote I/O top level
    SPI slave, frame mapper, two stepper joints, PWM output and
    frequency input
*/
`default_nettype none

module rioTop import rioPkg::*; (
    input  logic                  sysclk,
    input  logic                  reset,
    input  logic                  spiSck,
    input  logic                  spiSsel,
    input  logic                  spiMosi,
    output logic                  spiMiso,
    input  logic [7:0]            din,
    output logic [7:0]            dout,
    output logic [jointCount-1:0] stp,
    output logic [jointCount-1:0] dir,
    output logic                  ena,
    output logic                  errorOut,
    output logic                  pwm,
    input  logic                  vinFrequency
);

    logic [frameBits-1:0] rxFrame;
    logic [frameBits-1:0] txFrame;
    logic rxValid;
    logic linkError;
    logic signed [31:0] freqCmd0;
    logic signed [31:0] freqCmd1;
    logic signed [31:0] setPoint;
    logic [jointCount-1:0] jointEnable;
    logic pwmDisable;
    logic signed [31:0] feedback0;
    logic signed [31:0] feedback1;
    logic signed [31:0] processVariable;

    assign errorOut = linkError;

    spiSlave spi (
        .sysclk    (sysclk),
        .reset     (reset),
        .spiSck    (spiSck),
        .spiSsel   (spiSsel),
        .spiMosi   (spiMosi),
        .spiMiso   (spiMiso),
        .txFrame   (txFrame),
        .rxFrame   (rxFrame),
        .rxValid   (rxValid),
        .linkError (linkError)
    );

    frameMapper mapper (
        .sysclk          (sysclk),
        .reset           (reset),
        .rxFrame         (rxFrame),
        .rxValid         (rxValid),
        .linkError       (linkError),
        .freqCmd0        (freqCmd0),
        .freqCmd1        (freqCmd1),
        .setPoint        (setPoint),
        .jointEnable     (jointEnable),
        .pwmDisable      (pwmDisable),
        .ena             (ena),
        .dout            (dout),
        .feedback0       (feedback0),
        .feedback1       (feedback1),
        .processVariable (processVariable),
        .din             (din),
        .txFrame         (txFrame)
    );

    jointStepper joint0 (
        .sysclk   (sysclk),
        .reset    (reset),
        .enable   (jointEnable[0]),
        .freqCmd  (freqCmd0),
        .stp      (stp[0]),
        .dir      (dir[0]),
        .feedback (feedback0)
    );

    jointStepper joint1 (
        .sysclk   (sysclk),
        .reset    (reset),
        .enable   (jointEnable[1]),
        .freqCmd  (freqCmd1),
        .stp      (stp[1]),
        .dir      (dir[1]),
        .feedback (feedback1)
    );

    pwmOut pwm0 (
        .sysclk   (sysclk),
        .reset    (reset),
        .setPoint (setPoint),
        .disabled (pwmDisable),
        .pwm      (pwm)
    );

    freqCounter vin0 (
        .sysclk    (sysclk),
        .reset     (reset),
        .signalIn  (vinFrequency),
        .frequency (processVariable)
    );

endmodule

`default_nettype wire

// File: tbClock.sv
/*
    Testbench clock and reset
    20 ns sysclk, reset held for the first 10 cycles
*/
`default_nettype none

module tbClock (
    output logic sysclk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int resetCycles = 10;

    initial begin
        sysclk = 1'b0;
        forever #10 sysclk = !sysclk;
    end

    // reset drops on a falling edge like every other input
    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(posedge sysclk);
        @(negedge sysclk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// File: rioTb.sv
/*
    Remote I/O testbench
    SPI host model, directed tests for link watchdog, outputs, steppers,
    PWM and frequency input
*/
`default_nettype none

module rioTb import rioPkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    // SCK runs at 2 * halfBit sysclk cycles per bit
    localparam int halfBit = 4;
    localparam int settleCycles = 8;
    localparam int frameCycles = 4 + frameBits * 2 * halfBit + halfBit + settleCycles + 1;
    localparam int runCycles = 2000;
    localparam int testCycles = 10 * frameCycles + 2 * timeoutCycles + 2 * freqGate
                                + runCycles + 1000;
    localparam int watchdogCycles = testCycles + 2000;

    localparam logic [31:0] hostHeader = "tirw";
    localparam logic [31:0] replyData = "data";
    localparam logic [31:0] replyEstop = "estp";
    localparam logic [31:0] lfsrTaps = 32'h80200003;
    localparam int vinHalf = 20;
    localparam int vinEdges = freqGate / (2 * vinHalf);

    logic sysclk;
    logic reset;
    logic spiSck = 1'b0;
    logic spiSsel = 1'b1;
    logic spiMosi = 1'b0;
    logic spiMiso;
    logic [7:0] din = 8'h00;
    logic [7:0] dout;
    logic [jointCount-1:0] stp;
    logic [jointCount-1:0] dir;
    logic ena;
    logic errorOut;
    logic pwm;
    logic vinFrequency = 1'b0;

    logic [31:0] lfsrState = 32'd40;
    logic [7:0] sentDout;
    logic countSteps = 1'b0;
    logic [jointCount-1:0] stpLast = '0;
    int stepCount0 = 0;
    int stepCount1 = 0;
    logic vinRun = 1'b0;
    int vinPhase = 0;

    tbClock clockGen (
        .sysclk (sysclk),
        .reset  (reset)
    );

    rioTop u_dut (
        .sysclk       (sysclk),
        .reset        (reset),
        .spiSck       (spiSck),
        .spiSsel      (spiSsel),
        .spiMosi      (spiMosi),
        .spiMiso      (spiMiso),
        .din          (din),
        .dout         (dout),
        .stp          (stp),
        .dir          (dir),
        .ena          (ena),
        .errorOut     (errorOut),
        .pwm          (pwm),
        .vinFrequency (vinFrequency)
    );

    task automatic stopRun();
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compareWord(input string name, input logic signed [31:0] expected,
                               input logic signed [31:0] actual);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s expected %0d (%h) got %0d (%h)",
                     $time, name, expected, expected, actual, actual);
            stopRun();
        end
    endtask

    task automatic compareByte(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s expected %h got %h", $time, name, expected, actual);
            stopRun();
        end
    endtask

    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ lfsrTaps;
        end
        return state >> 1;
    endfunction

    // one LFSR step per bit taken
    task automatic randomBits(input int count, output logic [31:0] value);
        int i;
        value = '0;
        for (i = 0; i < count; i++) begin
            value = {value[30:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    // least significant byte goes out first
    function automatic logic [31:0] wireOrder(input logic [31:0] value);
        logic [31:0] result;
        int b;
        for (b = 0; b < 4; b++) begin
            result[8 * (3 - b) +: 8] = value[8 * b +: 8];
        end
        return result;
    endfunction

    function automatic logic [frameBits-1:0] hostFrame(input logic [31:0] header,
            input logic [31:0] cmd0, input logic [31:0] cmd1, input logic [31:0] setPt,
            input logic [7:0] enables, input logic [7:0] outBits);
        return {wireOrder(header), wireOrder(cmd0), wireOrder(cmd1), wireOrder(setPt),
                enables, outBits};
    endfunction

    // 0 header, 1 and 2 joint feedback, 3 process variable
    function automatic logic signed [31:0] replyWord(input logic [frameBits-1:0] reply,
                                                     input int index);
        return wireOrder(reply[frameBits - 1 - 32 * index -: 32]);
    endfunction

    task automatic exchangeFrame(input logic [frameBits-1:0] hostBits,
                                 output logic [frameBits-1:0] replyBits);
        int i;
        @(negedge sysclk);
        spiSsel = 1'b0;
        repeat (4) @(negedge sysclk);
        for (i = frameBits - 1; i >= 0; i--) begin
            spiMosi = hostBits[i];
            repeat (halfBit) @(negedge sysclk);
            replyBits[i] = spiMiso;
            spiSck = 1'b1;
            repeat (halfBit) @(negedge sysclk);
            spiSck = 1'b0;
        end
        repeat (halfBit) @(negedge sysclk);
        spiSsel = 1'b1;
        spiMosi = 1'b0;
        // rxValid follows 2 to 4 cycles after release and the commands one cycle later
        repeat (settleCycles) @(negedge sysclk);
    endtask

    task automatic countHigh(input int cycles, output logic signed [31:0] highCount);
        int n;
        highCount = 0;
        for (n = 0; n < cycles; n++) begin
            @(negedge sysclk);
            if (pwm) begin
                highCount = highCount + 1;
            end
        end
    endtask

    task automatic waitForError();
        int n;
        for (n = 0; n < timeoutCycles + 100 && !errorOut; n++) begin
            @(negedge sysclk);
        end
        if (!errorOut) begin
            $display("errorOut did not rise after the host stopped sending");
            stopRun();
        end
    endtask

    task automatic afterReset();
        logic [frameBits-1:0] reply;
        int n;
        for (n = 0; n < timeoutCycles + 10; n++) begin
            @(negedge sysclk);
            compareByte("ena", 8'h00, 8'(ena));
            compareByte("stp", 8'h00, 8'(stp));
            compareByte("pwm", 8'h00, 8'(pwm));
            compareByte("dout", 8'h00, dout);
            // still well inside the timeout
            if (n < timeoutCycles - 5) begin
                compareByte("errorOut", 8'h00, 8'(errorOut));
            end
        end
        compareByte("errorOut", 8'h01, 8'(errorOut));
        exchangeFrame('0, reply);
        compareWord("reply header", replyEstop, replyWord(reply, 0));
        compareByte("errorOut", 8'h01, 8'(errorOut));
    endtask

    task automatic validFrame();
        logic [frameBits-1:0] reply;
        logic [31:0] value;
        randomBits(8, value);
        sentDout = value[7:0];
        randomBits(8, value);
        din = value[7:0];
        exchangeFrame(hostFrame(hostHeader, 0, 0, 0, 8'h03, sentDout), reply);
        compareByte("errorOut", 8'h00, 8'(errorOut));
        compareByte("dout", sentDout, dout);
        compareByte("ena", 8'h01, 8'(ena));
        exchangeFrame(hostFrame(hostHeader, 0, 0, 0, 8'h03, sentDout), reply);
        compareWord("reply header", replyData, replyWord(reply, 0));
        compareByte("reply din", din, reply[15:8]);
        compareByte("reply pad", 8'h00, reply[7:0]);
    endtask

    task automatic wrongHeader();
        logic [frameBits-1:0] reply;
        exchangeFrame(hostFrame("xxxx", 0, 0, 0, 8'h00, ~sentDout), reply);
        compareByte("dout", sentDout, dout);
        compareByte("ena", 8'h01, 8'(ena));
        compareByte("errorOut", 8'h00, 8'(errorOut));
        compareWord("reply header", replyData, replyWord(reply, 0));
    endtask

    task automatic jointMotion();
        logic [frameBits-1:0] reply;
        logic [31:0] value;
        logic signed [31:0] cmdPos;
        logic signed [31:0] cmdNeg;
        logic signed [31:0] base0;
        logic signed [31:0] base1;
        int steps0;
        int steps1;
        // roughly one step every 13 to 64 cycles
        randomBits(20, value);
        cmdPos = 32'h0004_0000 + {12'h000, value[19:0]};
        randomBits(20, value);
        cmdNeg = -(32'h0004_0000 + {12'h000, value[19:0]});
        countSteps = 1'b1;
        exchangeFrame(hostFrame(hostHeader, cmdPos, cmdNeg, 0, 8'h03, sentDout), reply);
        base0 = replyWord(reply, 1);
        base1 = replyWord(reply, 2);
        repeat (runCycles) @(negedge sysclk);
        compareByte("dir[0]", 8'(cmdPos < 0), 8'(dir[0]));
        compareByte("dir[1]", 8'(cmdNeg < 0), 8'(dir[1]));
        if (stepCount0 == 0 || stepCount1 == 0) begin
            $display("a joint produced no step pulses while enabled");
            stopRun();
        end
        exchangeFrame(hostFrame(hostHeader, cmdPos, cmdNeg, 0, 8'h00, sentDout), reply);
        compareByte("ena", 8'h00, 8'(ena));
        steps0 = stepCount0;
        steps1 = stepCount1;
        countSteps = 1'b0;
        exchangeFrame(hostFrame(hostHeader, cmdPos, cmdNeg, 0, 8'h00, sentDout), reply);
        compareWord("feedback0", base0 + steps0, replyWord(reply, 1));
        compareWord("feedback1", base1 - steps1, replyWord(reply, 2));
        compareByte("dir[1] held", 8'h01, 8'(dir[1]));
    endtask

    task automatic pwmDuty();
        logic [frameBits-1:0] reply;
        logic signed [31:0] highCount;
        // any 3 whole periods hold exactly 3 times the duty
        exchangeFrame(hostFrame(hostHeader, 0, 0, 30, 8'h01, sentDout), reply);
        countHigh(3 * pwmPeriod, highCount);
        compareWord("pwm high cycles", 90, highCount);
        exchangeFrame(hostFrame(hostHeader, 0, 0, 150, 8'h01, sentDout), reply);
        countHigh(3 * pwmPeriod, highCount);
        compareWord("pwm high cycles", 3 * pwmPeriod, highCount);
        compareByte("ena", 8'h01, 8'(ena));
        waitForError();
        repeat (2) @(negedge sysclk);
        countHigh(pwmPeriod, highCount);
        compareWord("pwm high cycles in error", 0, highCount);
        compareByte("ena", 8'h00, 8'(ena));
    endtask

    task automatic inputFrequency();
        logic [frameBits-1:0] reply;
        logic signed [31:0] measured;
        vinRun = 1'b1;
        repeat (2 * freqGate + 100) @(negedge sysclk);
        exchangeFrame(hostFrame(hostHeader, 0, 0, 0, 8'h00, sentDout), reply);
        vinRun = 1'b0;
        measured = replyWord(reply, 3);
        // window phase may gain or lose one edge
        if (measured < vinEdges - 1 || measured > vinEdges + 1) begin
            $display("Fail at %0t ns: processVariable expected %0d +/- 1 got %0d",
                     $time, vinEdges, measured);
            stopRun();
        end
    endtask

    // step edges counted at the ports while counting is on
    always @(negedge sysclk) begin
        if (!countSteps) begin
            stepCount0 <= 0;
            stepCount1 <= 0;
        end else begin
            if (stp[0] && !stpLast[0]) begin
                stepCount0 <= stepCount0 + 1;
            end
            if (stp[1] && !stpLast[1]) begin
                stepCount1 <= stepCount1 + 1;
            end
        end
        stpLast <= stp;
    end

    always @(negedge sysclk) begin
        if (vinRun) begin
            if (vinPhase == vinHalf - 1) begin
                vinPhase <= 0;
                vinFrequency <= !vinFrequency;
            end else begin
                vinPhase <= vinPhase + 1;
            end
        end
    end

    initial begin
        repeat (watchdogCycles) @(posedge sysclk);
        $display("watchdog expired before the tests finished");
        stopRun();
    end

    initial begin
        wait (reset === 1'b0);
        @(negedge sysclk);
        $display("test: state after reset");
        afterReset();
        $display("test: valid frame");
        validFrame();
        $display("test: wrong header");
        wrongHeader();
        $display("test: joint motion");
        jointMotion();
        $display("test: pwm duty and timeout");
        pwmDuty();
        $display("test: input frequency");
        inputFrequency();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: rioTop.f
rioPkg.sv
spiSlave.sv
frameMapper.sv
jointStepper.sv
pwmOut.sv
freqCounter.sv
rioTop.sv
tbClock.sv
rioTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the remote I/O testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module rioTb -f rioTop.f -o rioSim

# the simulator exits non-zero on $fatal, tee keeps the log for the search below
./obj_dir/rioSim | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    exit 0
else
    exit 1
fi
